// ==== src.f ====
+incdir+.
i2cm_cfg_pkg.sv
i2cm_arb_pkg.sv
i2cm_if.sv
i2cm_trig_capture.sv
i2cm_arb_fsm.sv
i2cm_xfer_setup.sv
i2cm_event_notify.sv
i2cm_arb_top.sv
tb_i2cm_arb.sv

// ==== Makefile ====
# Verilator build and regression run for the I2C trigger arbiter

VERILATOR ?= verilator
TOP       ?= tb_i2cm_arb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the exit status catches a crash or a failed assertion
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Regression failed" $(LOG); then exit 1; fi; \
	if ! grep -q "Regression passed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_i2cm_arb.sv ====
`default_nettype none

module tb_i2cm_arb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_TESTS  = 32;
   localparam int CLK_PERIOD = 10;
   localparam int WAIT_LIMIT = 20;

   logic                     i2c_clk = 1'b0;
   logic                     i2c_rst_n;
   logic                     i_trg_0, i_trg_1;
   logic                     i_stb_0, i_stb_1, i_seq_0, i_seq_1;
   logic                     i_nack_0, i_nack_1, i_type_0, i_type_1;
   i2cm_cfg_pkg::dev_id_t    i_dev_id_0, i_dev_id_1;
   i2cm_cfg_pkg::reg_addr_t  i_addr_0, i_addr_1;
   i2cm_cfg_pkg::byte_num_t  i_num_0, i_num_1;
   logic                     i_finish_pulse, i_wdata_nack, i_clr_smo;
   logic                     i_addr_done, i_num_cnt_inc;
   i2cm_cfg_pkg::byte_num_t  i_num_cnt;
   i2cm_cfg_pkg::reg_addr_t  i_addr_cnt;
   i2cm_cfg_pkg::data_byte_t i_data;
   logic                     o_finish_tgl_0, o_finish_tgl_1, o_nack_tgl_0, o_nack_tgl_1;
   logic                     o_abr_op, o_abr_trg_cfg, o_abr_int_flag;
   logic                     o_abr_stb_cfg, o_abr_seq_cfg, o_abr_nack_cfg, o_abr_type_cfg;
   i2cm_cfg_pkg::dev_id_t    o_abr_dev_id_cfg;
   i2cm_cfg_pkg::byte_num_t  o_abr_num;
   i2cm_cfg_pkg::reg_addr_t  o_abr_addr;
   i2cm_cfg_pkg::data_byte_t o_abr_data;

   // reference model state
   logic [31:0]              rng_state = 32'd88;
   logic [1:0]               exp_fin;
   logic [1:0]               exp_nack;
   i2cm_cfg_pkg::reg_addr_t  kept_addr;
   i2cm_cfg_pkg::byte_num_t  kept_num;
   logic                     data_live;
   int                       errors;
   int                       checks;

   i2cm_arb_top i2cm_arb_top_inst (.*);

   always #(CLK_PERIOD / 2) i2c_clk = ~i2c_clk;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check_bit(input logic got, input logic want, input string name);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
      end
   endtask

   task automatic check_cfg(input i2cm_cfg_pkg::dev_id_t got,
                            input i2cm_cfg_pkg::dev_id_t want, input string name);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, want, $time);
      end
   endtask

   task automatic check_addr(input i2cm_cfg_pkg::reg_addr_t got,
                             input i2cm_cfg_pkg::reg_addr_t want, input string name);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, want, $time);
      end
   endtask

   task automatic check_num(input i2cm_cfg_pkg::byte_num_t got,
                            input i2cm_cfg_pkg::byte_num_t want, input string name);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
      end
   endtask

   task automatic check_data(input i2cm_cfg_pkg::data_byte_t got,
                             input i2cm_cfg_pkg::data_byte_t want, input string name);
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, want, $time);
      end
   endtask

   // check the data passthrough once a clock and move the engine counters on
   task automatic step();
      logic [31:0] r;
      @(negedge i2c_clk);
      if (data_live) begin
         check_data(o_abr_data, i_data, "o_abr_data");
      end
      r = next_rand();
      i_num_cnt  = r[3:0];
      i_addr_cnt = r[11:4];
      i_data     = r[19:12];
   endtask

   task automatic randomize_cfg();
      logic [31:0] r;
      r = next_rand();
      i_dev_id_0 = r[7:0];
      i_dev_id_1 = r[15:8];
      i_addr_0   = r[23:16];
      i_addr_1   = r[31:24];
      r = next_rand();
      i_num_0  = r[3:0];
      i_num_1  = r[7:4];
      {i_stb_0, i_stb_1, i_seq_0, i_seq_1} = r[11:8];
      {i_nack_0, i_nack_1, i_type_0, i_type_1} = r[15:12];
   endtask

   // sel 0 waits for o_abr_op, sel 1 for o_abr_int_flag
   task automatic wait_high(input logic sel, input string what);
      int   n;
      logic seen;
      n = 0;
      seen = sel ? o_abr_int_flag : o_abr_op;
      while (!seen && n < WAIT_LIMIT) begin
         step();
         n++;
         seen = sel ? o_abr_int_flag : o_abr_op;
      end
      if (!seen) begin
         errors++;
         $display("%s did not rise within %0d cycles at %0t", what, WAIT_LIMIT, $time);
      end
   endtask

   task automatic pulse_trig(input logic [1:0] which, input int width);
      i_trg_0 = which[0];
      i_trg_1 = which[1];
      repeat (width) step();
      i_trg_0 = 1'b0;
      i_trg_1 = 1'b0;
   endtask

   task automatic check_toggles();
      check_bit(o_finish_tgl_0, exp_fin[0], "o_finish_tgl_0");
      check_bit(o_finish_tgl_1, exp_fin[1], "o_finish_tgl_1");
      check_bit(o_nack_tgl_0, exp_nack[0], "o_nack_tgl_0");
      check_bit(o_nack_tgl_1, exp_nack[1], "o_nack_tgl_1");
   endtask

   task automatic check_chan_cfg(input logic ch);
      check_bit(o_abr_stb_cfg, ch ? i_stb_1 : i_stb_0, "o_abr_stb_cfg");
      check_bit(o_abr_seq_cfg, ch ? i_seq_1 : i_seq_0, "o_abr_seq_cfg");
      check_bit(o_abr_nack_cfg, ch ? i_nack_1 : i_nack_0, "o_abr_nack_cfg");
      check_bit(o_abr_type_cfg, ch ? i_type_1 : i_type_0, "o_abr_type_cfg");
      check_cfg(o_abr_dev_id_cfg, ch ? i_dev_id_1 : i_dev_id_0, "o_abr_dev_id_cfg");
   endtask

   // nack held for two cycles gives one pulse
   task automatic send_nack(input logic ch);
      i_wdata_nack = 1'b1;
      repeat (2) step();
      i_wdata_nack = 1'b0;
      exp_nack[ch] = ~exp_nack[ch];
      check_toggles();
   endtask

   task automatic finish_op(input logic ch, input logic to_idle);
      i_finish_pulse = 1'b1;
      step();
      i_finish_pulse = 1'b0;
      exp_fin[ch] = ~exp_fin[ch];
      check_toggles();
      check_bit(o_abr_op, ~to_idle, "o_abr_op");
   endtask

   // engine side of one operation on channel ch
   task automatic serve(input logic ch, input logic inject_nack, input logic to_idle);
      int n;
      check_chan_cfg(ch);
      check_bit(o_abr_trg_cfg, 1'b1, "o_abr_trg_cfg");
      i_addr_done = 1'b1;
      step();
      i_addr_done = 1'b0;
      check_num(o_abr_num, ch ? i_num_1 : i_num_0, "o_abr_num");
      if (inject_nack) begin
         send_nack(ch);
      end
      n = 1 + int'(next_rand() % 32'd8);
      repeat (n) step();
      finish_op(ch, to_idle);
   endtask

   task automatic idle_gap();
      int n;
      n = 2 + int'(next_rand() % 32'd6);
      repeat (n) step();
      check_bit(o_abr_op, 1'b0, "o_abr_op");
      check_num(o_abr_num, '0, "o_abr_num");
   endtask

   task automatic run_single(input logic ch);
      logic [31:0] r;
      r = next_rand();
      pulse_trig(ch ? 2'b10 : 2'b01, 1 + int'(r[0]));
      wait_high(1'b0, "o_abr_op");
      i_clr_smo = 1'b0;
      serve(ch, r[1], 1'b1);
      i_clr_smo = 1'b1;
   endtask

   task automatic run_both();
      logic [31:0] r;
      r = next_rand();
      pulse_trig(2'b11, 1);
      wait_high(1'b0, "o_abr_op");
      i_clr_smo = 1'b0;
      serve(1'b0, r[0], 1'b1);
      i_clr_smo = 1'b1;
      wait_high(1'b0, "o_abr_op");
      i_clr_smo = 1'b0;
      serve(1'b1, r[1], 1'b1);
      i_clr_smo = 1'b1;
   endtask

   task automatic run_preempt();
      logic [31:0] r;
      r = next_rand();
      pulse_trig(2'b10, 1);
      wait_high(1'b0, "o_abr_op");
      i_clr_smo = 1'b0;
      check_chan_cfg(1'b1);
      check_bit(o_abr_int_flag, 1'b0, "o_abr_int_flag");
      // channel 0 asks while channel 1 is moving bytes
      pulse_trig(2'b01, 1);
      i_num_cnt_inc = 1'b1;
      wait_high(1'b1, "o_abr_int_flag");
      i_num_cnt_inc = 1'b0;
      check_bit(o_abr_op, 1'b1, "o_abr_op");
      check_bit(o_abr_trg_cfg, 1'b0, "o_abr_trg_cfg");
      // engine clears and the arbiter keeps the channel 1 position
      i_clr_smo = 1'b1;
      kept_addr = i_addr_cnt;
      kept_num  = i_num_cnt;
      step();
      i_clr_smo = 1'b0;
      serve(1'b0, r[0], 1'b0);
      check_bit(o_abr_trg_cfg, 1'b1, "o_abr_trg_cfg");
      check_chan_cfg(1'b1);
      step();
      check_addr(o_abr_addr, kept_addr, "o_abr_addr");
      check_num(o_abr_num, kept_num, "o_abr_num");
      // resumed data phase
      i_addr_done = 1'b1;
      step();
      i_addr_done = 1'b0;
      check_num(o_abr_num, i_num_1, "o_abr_num");
      check_bit(o_abr_trg_cfg, 1'b0, "o_abr_trg_cfg");
      repeat (int'(r[3:2])) step();
      // nack sends the address again from the kept value
      send_nack(1'b1);
      step();
      check_addr(o_abr_addr, kept_addr, "o_abr_addr");
      check_bit(o_abr_trg_cfg, 1'b1, "o_abr_trg_cfg");
      finish_op(1'b1, 1'b1);
      check_bit(o_abr_int_flag, 1'b0, "o_abr_int_flag");
      i_clr_smo = 1'b1;
   endtask

   initial begin
      logic [31:0] r;
      errors    = 0;
      checks    = 0;
      exp_fin   = '0;
      exp_nack  = '0;
      data_live = 1'b0;
      i2c_rst_n = 1'b0;
      i_trg_0 = 1'b0;
      i_trg_1 = 1'b0;
      i_finish_pulse = 1'b0;
      i_wdata_nack   = 1'b0;
      i_addr_done    = 1'b0;
      i_num_cnt_inc  = 1'b0;
      i_clr_smo      = 1'b1;
      i_num_cnt  = '0;
      i_addr_cnt = '0;
      i_data     = '0;
      randomize_cfg();
      repeat (2) @(negedge i2c_clk);
      check_toggles();
      check_bit(o_abr_op, 1'b0, "o_abr_op");
      check_bit(o_abr_trg_cfg, 1'b0, "o_abr_trg_cfg");
      check_bit(o_abr_int_flag, 1'b0, "o_abr_int_flag");
      check_num(o_abr_num, '0, "o_abr_num");
      check_addr(o_abr_addr, '0, "o_abr_addr");
      i2c_rst_n = 1'b1;
      data_live = 1'b1;
      for (int t = 0; t < NUM_TESTS; t++) begin
         randomize_cfg();
         idle_gap();
         r = next_rand();
         case (r[1:0])
            2'd0: run_single(1'b0);
            2'd1: run_single(1'b1);
            2'd2: run_both();
            default: run_preempt();
         endcase
      end
      idle_gap();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // 200 cycles per test is far beyond the longest scenario
   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("run stopped by the watchdog, tests did not complete in time");
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== i2cm_arb_top.sv ====
`default_nettype none

module i2cm_arb_top (
   input  wire                              i2c_clk,
   input  wire                              i2c_rst_n,
   input  wire                              i_trg_0,
   input  wire                              i_trg_1,
   input  wire                              i_stb_0,
   input  wire                              i_stb_1,
   input  wire                              i_seq_0,
   input  wire                              i_seq_1,
   input  wire                              i_nack_0,
   input  wire                              i_nack_1,
   input  wire                              i_type_0,
   input  wire                              i_type_1,
   input  wire i2cm_cfg_pkg::dev_id_t       i_dev_id_0,
   input  wire i2cm_cfg_pkg::dev_id_t       i_dev_id_1,
   input  wire i2cm_cfg_pkg::reg_addr_t     i_addr_0,
   input  wire i2cm_cfg_pkg::reg_addr_t     i_addr_1,
   input  wire i2cm_cfg_pkg::byte_num_t     i_num_0,
   input  wire i2cm_cfg_pkg::byte_num_t     i_num_1,
   input  wire                              i_finish_pulse,
   input  wire                              i_wdata_nack,
   input  wire i2cm_cfg_pkg::byte_num_t     i_num_cnt,
   input  wire i2cm_cfg_pkg::reg_addr_t     i_addr_cnt,
   input  wire i2cm_cfg_pkg::data_byte_t    i_data,
   input  wire                              i_clr_smo,
   input  wire                              i_addr_done,
   input  wire                              i_num_cnt_inc,
   output logic                             o_finish_tgl_0,
   output logic                             o_finish_tgl_1,
   output logic                             o_nack_tgl_0,
   output logic                             o_nack_tgl_1,
   output logic                             o_abr_op,
   output logic                             o_abr_trg_cfg,
   output logic                             o_abr_stb_cfg,
   output logic                             o_abr_seq_cfg,
   output logic                             o_abr_nack_cfg,
   output logic                             o_abr_type_cfg,
   output i2cm_cfg_pkg::dev_id_t            o_abr_dev_id_cfg,
   output i2cm_cfg_pkg::byte_num_t          o_abr_num,
   output i2cm_cfg_pkg::reg_addr_t          o_abr_addr,
   output i2cm_cfg_pkg::data_byte_t         o_abr_data,
   output logic                             o_abr_int_flag
);

   logic pend_0;
   logic pend_1;

   i2cm_eng_if     eng_if ();
   i2cm_arb_ctl_if ctl_if ();

   // engine status onto the shared bundle
   assign eng_if.finish_pulse = i_finish_pulse;
   assign eng_if.wdata_nack   = i_wdata_nack;
   assign eng_if.num_cnt      = i_num_cnt;
   assign eng_if.addr_cnt     = i_addr_cnt;
   assign eng_if.data         = i_data;
   assign eng_if.clr_smo      = i_clr_smo;
   assign eng_if.addr_done    = i_addr_done;
   assign eng_if.num_cnt_inc  = i_num_cnt_inc;

   i2cm_trig_capture i2cm_trig_capture_inst (
      .i2c_clk   (i2c_clk),
      .i2c_rst_n (i2c_rst_n),
      .i_trg_0   (i_trg_0),
      .i_trg_1   (i_trg_1),
      .ctl       (ctl_if.mon),
      .o_pend_0  (pend_0),
      .o_pend_1  (pend_1)
   );

   i2cm_arb_fsm i2cm_arb_fsm_inst (
      .i2c_clk        (i2c_clk),
      .i2c_rst_n      (i2c_rst_n),
      .i_pend_0       (pend_0),
      .i_pend_1       (pend_1),
      .eng            (eng_if.snk),
      .ctl            (ctl_if.drv),
      .o_abr_op       (o_abr_op),
      .o_abr_trg_cfg  (o_abr_trg_cfg),
      .o_abr_int_flag (o_abr_int_flag)
   );

   i2cm_xfer_setup i2cm_xfer_setup_inst (
      .i2c_clk          (i2c_clk),
      .i2c_rst_n        (i2c_rst_n),
      .eng              (eng_if.snk),
      .ctl              (ctl_if.mon),
      .i_stb_0          (i_stb_0),
      .i_stb_1          (i_stb_1),
      .i_seq_0          (i_seq_0),
      .i_seq_1          (i_seq_1),
      .i_nack_0         (i_nack_0),
      .i_nack_1         (i_nack_1),
      .i_type_0         (i_type_0),
      .i_type_1         (i_type_1),
      .i_dev_id_0       (i_dev_id_0),
      .i_dev_id_1       (i_dev_id_1),
      .i_addr_0         (i_addr_0),
      .i_addr_1         (i_addr_1),
      .i_num_0          (i_num_0),
      .i_num_1          (i_num_1),
      .o_abr_stb_cfg    (o_abr_stb_cfg),
      .o_abr_seq_cfg    (o_abr_seq_cfg),
      .o_abr_nack_cfg   (o_abr_nack_cfg),
      .o_abr_type_cfg   (o_abr_type_cfg),
      .o_abr_dev_id_cfg (o_abr_dev_id_cfg),
      .o_abr_num        (o_abr_num),
      .o_abr_addr       (o_abr_addr),
      .o_abr_data       (o_abr_data)
   );

   i2cm_event_notify i2cm_event_notify_inst (
      .i2c_clk        (i2c_clk),
      .i2c_rst_n      (i2c_rst_n),
      .eng            (eng_if.snk),
      .ctl            (ctl_if.mon),
      .o_finish_tgl_0 (o_finish_tgl_0),
      .o_finish_tgl_1 (o_finish_tgl_1),
      .o_nack_tgl_0   (o_nack_tgl_0),
      .o_nack_tgl_1   (o_nack_tgl_1)
   );

endmodule

`default_nettype wire

// ==== i2cm_event_notify.sv ====
`default_nettype none

module i2cm_event_notify (
   input  wire            i2c_clk,
   input  wire            i2c_rst_n,
   i2cm_eng_if.snk        eng,
   i2cm_arb_ctl_if.mon    ctl,
   output logic           o_finish_tgl_0,
   output logic           o_finish_tgl_1,
   output logic           o_nack_tgl_0,
   output logic           o_nack_tgl_1
);

   logic       wdata_nack_q;
   logic       nack_pulse;
   logic [1:0] chan_act;
   logic [1:0] finish_tgl;
   logic [1:0] nack_tgl;

   assign nack_pulse = eng.wdata_nack & wdata_nack_q;

   // channel 1 also owns the resumed states
   assign chan_act[0] = (ctl.state == i2cm_arb_pkg::TRG0_OP);
   assign chan_act[1] = (ctl.state == i2cm_arb_pkg::TRG1_OP) ||
                        (ctl.state == i2cm_arb_pkg::INT_1ST_ADDR) ||
                        (ctl.state == i2cm_arb_pkg::INT_DATA);

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         wdata_nack_q <= 1'b0;
         finish_tgl   <= '0;
         nack_tgl     <= '0;
      end else begin
         wdata_nack_q <= eng.wdata_nack;
         finish_tgl   <= finish_tgl ^ (chan_act & {2{eng.finish_pulse}});
         nack_tgl     <= nack_tgl ^ (chan_act & {2{nack_pulse}});
      end
   end

   assign o_finish_tgl_0 = finish_tgl[0];
   assign o_finish_tgl_1 = finish_tgl[1];
   assign o_nack_tgl_0   = nack_tgl[0];
   assign o_nack_tgl_1   = nack_tgl[1];

   // a nack held longer than two cycles would flip the toggle again
   a_nack_two_cycles: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      nack_pulse |=> !eng.wdata_nack);

endmodule

`default_nettype wire

// ==== i2cm_xfer_setup.sv ====
`default_nettype none

module i2cm_xfer_setup (
   input  wire                              i2c_clk,
   input  wire                              i2c_rst_n,
   i2cm_eng_if.snk                          eng,
   i2cm_arb_ctl_if.mon                      ctl,
   input  wire                              i_stb_0,
   input  wire                              i_stb_1,
   input  wire                              i_seq_0,
   input  wire                              i_seq_1,
   input  wire                              i_nack_0,
   input  wire                              i_nack_1,
   input  wire                              i_type_0,
   input  wire                              i_type_1,
   input  wire i2cm_cfg_pkg::dev_id_t       i_dev_id_0,
   input  wire i2cm_cfg_pkg::dev_id_t       i_dev_id_1,
   input  wire i2cm_cfg_pkg::reg_addr_t     i_addr_0,
   input  wire i2cm_cfg_pkg::reg_addr_t     i_addr_1,
   input  wire i2cm_cfg_pkg::byte_num_t     i_num_0,
   input  wire i2cm_cfg_pkg::byte_num_t     i_num_1,
   output logic                             o_abr_stb_cfg,
   output logic                             o_abr_seq_cfg,
   output logic                             o_abr_nack_cfg,
   output logic                             o_abr_type_cfg,
   output i2cm_cfg_pkg::dev_id_t            o_abr_dev_id_cfg,
   output i2cm_cfg_pkg::byte_num_t          o_abr_num,
   output i2cm_cfg_pkg::reg_addr_t          o_abr_addr,
   output i2cm_cfg_pkg::data_byte_t         o_abr_data
);

   logic                     sel_0;
   logic                     in_1st_addr;
   i2cm_cfg_pkg::reg_addr_t  addr_cfg;
   i2cm_cfg_pkg::byte_num_t  num_cfg;
   i2cm_cfg_pkg::reg_addr_t  addr_keep;
   i2cm_cfg_pkg::byte_num_t  num_keep;
   i2cm_cfg_pkg::reg_addr_t  addr_nxt;
   i2cm_cfg_pkg::byte_num_t  num_nxt;

   assign sel_0       = (ctl.chan == i2cm_arb_pkg::CH0);
   assign in_1st_addr = (ctl.state == i2cm_arb_pkg::INT_1ST_ADDR);

   // configuration of the channel owning the engine
   assign o_abr_stb_cfg    = sel_0 ? i_stb_0    : i_stb_1;
   assign o_abr_seq_cfg    = sel_0 ? i_seq_0    : i_seq_1;
   assign o_abr_nack_cfg   = sel_0 ? i_nack_0   : i_nack_1;
   assign o_abr_type_cfg   = sel_0 ? i_type_0   : i_type_1;
   assign o_abr_dev_id_cfg = sel_0 ? i_dev_id_0 : i_dev_id_1;
   assign addr_cfg         = sel_0 ? i_addr_0   : i_addr_1;
   assign num_cfg          = sel_0 ? i_num_0    : i_num_1;

   // track the engine counters, freeze them once channel 1 is preempted
   always_ff @(posedge i2c_clk) begin
      if (!ctl.restore) begin
         num_keep  <= eng.num_cnt;
         addr_keep <= eng.addr_cnt;
      end
   end

   // resumed address phase starts from where channel 1 stopped
   always_comb begin
      if (ctl.restore && in_1st_addr) begin
         addr_nxt = addr_keep;
      end else if (eng.clr_smo) begin
         addr_nxt = addr_cfg;
      end else begin
         addr_nxt = eng.addr_cnt;
      end
   end

   always_comb begin
      num_nxt = eng.addr_done ? num_cfg : num_keep;
      if (eng.clr_smo && !in_1st_addr) begin
         num_nxt = '0;
      end
   end

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         o_abr_num  <= '0;
         o_abr_addr <= '0;
         o_abr_data <= '0;
      end else begin
         o_abr_num  <= num_nxt;
         o_abr_addr <= addr_nxt;
         o_abr_data <= eng.data;
      end
   end

endmodule

`default_nettype wire

// ==== i2cm_arb_fsm.sv ====
`default_nettype none

module i2cm_arb_fsm (
   input  wire            i2c_clk,
   input  wire            i2c_rst_n,
   input  wire            i_pend_0,
   input  wire            i_pend_1,
   i2cm_eng_if.snk        eng,
   i2cm_arb_ctl_if.drv    ctl,
   output logic           o_abr_op,
   output logic           o_abr_trg_cfg,
   output logic           o_abr_int_flag
);

   i2cm_arb_pkg::arb_state_e state;
   i2cm_arb_pkg::arb_state_e state_nxt;
   logic                     restore;
   logic                     restore_nxt;
   logic                     wdata_nack_q;
   logic                     nack_pulse;

   // nack must be seen on two consecutive cycles
   assign nack_pulse = eng.wdata_nack & wdata_nack_q;

   always_comb begin
      state_nxt = state;
      case (state)
         i2cm_arb_pkg::IDLE: begin
            // channel 0 always wins
            if (i_pend_0) begin
               state_nxt = i2cm_arb_pkg::TRG0_OP;
            end else if (i_pend_1) begin
               state_nxt = i2cm_arb_pkg::TRG1_OP;
            end
         end
         i2cm_arb_pkg::TRG0_OP: begin
            if (eng.finish_pulse) begin
               state_nxt = restore ? i2cm_arb_pkg::INT_1ST_ADDR : i2cm_arb_pkg::IDLE;
            end
         end
         i2cm_arb_pkg::TRG1_OP: begin
            if (eng.finish_pulse) begin
               state_nxt = i2cm_arb_pkg::IDLE;
            end else if (eng.num_cnt_inc && i_pend_0) begin
               // preempt on a byte boundary
               state_nxt = i2cm_arb_pkg::WAIT_INT;
            end
         end
         i2cm_arb_pkg::WAIT_INT: begin
            if (eng.clr_smo) begin
               state_nxt = i2cm_arb_pkg::TRG0_OP;
            end
         end
         i2cm_arb_pkg::INT_1ST_ADDR: begin
            if (eng.addr_done) begin
               state_nxt = i2cm_arb_pkg::INT_DATA;
            end else if (eng.finish_pulse) begin
               state_nxt = i2cm_arb_pkg::IDLE;
            end
         end
         i2cm_arb_pkg::INT_DATA: begin
            // re-send the address after a nack
            if (nack_pulse) begin
               state_nxt = i2cm_arb_pkg::INT_1ST_ADDR;
            end else if (eng.finish_pulse) begin
               state_nxt = i2cm_arb_pkg::IDLE;
            end
         end
         default: state_nxt = i2cm_arb_pkg::IDLE;
      endcase
   end

   // set when channel 0 takes over from a preempted channel 1
   assign restore_nxt = ((state == i2cm_arb_pkg::WAIT_INT) & eng.clr_smo | restore) &
                        (state != i2cm_arb_pkg::IDLE);

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         state          <= i2cm_arb_pkg::IDLE;
         restore        <= 1'b0;
         wdata_nack_q   <= 1'b0;
         o_abr_int_flag <= 1'b0;
      end else begin
         state          <= state_nxt;
         restore        <= restore_nxt;
         wdata_nack_q   <= eng.wdata_nack;
         o_abr_int_flag <= (state == i2cm_arb_pkg::WAIT_INT);
      end
   end

   assign o_abr_op      = (state != i2cm_arb_pkg::IDLE);
   assign o_abr_trg_cfg = (state == i2cm_arb_pkg::TRG0_OP) ||
                          (state == i2cm_arb_pkg::TRG1_OP) ||
                          (state == i2cm_arb_pkg::INT_1ST_ADDR);

   assign ctl.state     = state;
   assign ctl.chan      = (state == i2cm_arb_pkg::TRG0_OP) ? i2cm_arb_pkg::CH0 :
                                                              i2cm_arb_pkg::CH1;
   assign ctl.restore   = restore;
   assign ctl.pend_clr0 = (state == i2cm_arb_pkg::TRG0_OP);
   assign ctl.pend_clr1 = (state == i2cm_arb_pkg::TRG1_OP);

   // the preempting request stays pending until channel 0 takes the engine
   a_int_flag_pend0: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      o_abr_int_flag |-> i_pend_0);

   // a finish while waiting for the engine to clear would be lost
   a_no_finish_in_wait: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      state == i2cm_arb_pkg::WAIT_INT |-> !eng.finish_pulse);

endmodule

`default_nettype wire

// ==== i2cm_trig_capture.sv ====
`default_nettype none

`include "i2cm_params.svh"

module i2cm_trig_capture (
   input  wire            i2c_clk,
   input  wire            i2c_rst_n,
   input  wire            i_trg_0,
   input  wire            i_trg_1,
   i2cm_arb_ctl_if.mon    ctl,
   output logic           o_pend_0,
   output logic           o_pend_1
);

   // one synchroniser row per channel
   logic [1:0][`I2CM_SYNC_STAGES-1:0] sync_q;
   logic [1:0]                        trg_in;
   logic [1:0]                        pend_clr;
   logic [1:0]                        pend_q;

   assign trg_in   = {i_trg_1, i_trg_0};
   assign pend_clr = {ctl.pend_clr1, ctl.pend_clr0};

   always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
      if (!i2c_rst_n) begin
         sync_q <= '0;
         pend_q <= '0;
      end else begin
         for (int ch = 0; ch < 2; ch++) begin
            sync_q[ch] <= {sync_q[ch][`I2CM_SYNC_STAGES-2:0], trg_in[ch]};
            // sticky until the channel's op state takes it
            pend_q[ch] <= (pend_q[ch] | sync_q[ch][`I2CM_SYNC_STAGES-1]) & ~pend_clr[ch];
         end
      end
   end

   assign o_pend_0 = pend_q[0];
   assign o_pend_1 = pend_q[1];

   // an op state is only entered while its request is still pending
   a_pend0_held_on_entry: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      $rose(ctl.pend_clr0) |-> o_pend_0);
   a_pend1_held_on_entry: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
      $rose(ctl.pend_clr1) |-> o_pend_1);

endmodule

`default_nettype wire

// ==== i2cm_if.sv ====
`default_nettype none

// status coming back from the I2C master engine
interface i2cm_eng_if;
   logic                    finish_pulse;
   logic                    wdata_nack;
   i2cm_cfg_pkg::byte_num_t num_cnt;
   i2cm_cfg_pkg::reg_addr_t addr_cnt;
   i2cm_cfg_pkg::data_byte_t data;
   // engine idle or clearing
   logic                    clr_smo;
   logic                    addr_done;
   logic                    num_cnt_inc;

   modport src (
      output finish_pulse, wdata_nack, num_cnt, addr_cnt, data,
      output clr_smo, addr_done, num_cnt_inc
   );

   modport snk (
      input finish_pulse, wdata_nack, num_cnt, addr_cnt, data,
      input clr_smo, addr_done, num_cnt_inc
   );
endinterface

// arbiter control, driven by the FSM
interface i2cm_arb_ctl_if;
   i2cm_arb_pkg::arb_state_e state;
   i2cm_arb_pkg::chan_e      chan;
   logic                     restore;
   logic                     pend_clr0;
   logic                     pend_clr1;

   modport drv (
      output state, chan, restore, pend_clr0, pend_clr1
   );

   modport mon (
      input state, chan, restore, pend_clr0, pend_clr1
   );
endinterface

`default_nettype wire

// ==== i2cm_arb_pkg.sv ====
`default_nettype none

package i2cm_arb_pkg;

   // arbiter control states
   typedef enum logic [2:0] {
      IDLE,
      // channel 0 owns the engine
      TRG0_OP,
      // channel 1 owns the engine
      TRG1_OP,
      // channel 1 preempted, waiting for the engine to drop back to idle
      WAIT_INT,
      // resumed channel 1, address phase
      INT_1ST_ADDR,
      // resumed channel 1, data phase
      INT_DATA
   } arb_state_e;

   // channel whose configuration is presented
   typedef enum logic {
      CH0,
      CH1
   } chan_e;

endpackage

`default_nettype wire

// ==== i2cm_cfg_pkg.sv ====
`default_nettype none

`include "i2cm_params.svh"

package i2cm_cfg_pkg;

   // 7-bit address plus r/w bit as the engine sends it
   typedef logic [`I2CM_BYTE_W-1:0] dev_id_t;

   // register address inside the device
   typedef logic [`I2CM_BYTE_W-1:0] reg_addr_t;

   // data byte passed through from the engine
   typedef logic [`I2CM_BYTE_W-1:0] data_byte_t;

   // bytes in one transfer, also the engine byte counter
   typedef logic [`I2CM_NUM_W-1:0] byte_num_t;

endpackage

`default_nettype wire

// ==== i2cm_params.svh ====
`ifndef I2CM_PARAMS_SVH
`define I2CM_PARAMS_SVH

// one I2C byte on the wire
`define I2CM_BYTE_W 8

// byte-count field of a transfer
`define I2CM_NUM_W 4

// flops in each trigger synchroniser
`define I2CM_SYNC_STAGES 2

`endif
